// File: common/periph_pkg.sv
`default_nettype none

package periph_pkg;

    // Bus and pin widths
    localparam int ADDR_W     = 11;
    localparam int DATA_W     = 32;
    localparam int PIN_W      = 8;

    // Slot layout
    localparam int NUM_SLOTS  = 16;
    localparam int SLOT_IDX_W = 4;
    localparam int FULL_OFS_W = 6;   // 64 bytes per full slot
    localparam int BYTE_OFS_W = 4;   // 16 bytes per byte slot

    localparam logic [SLOT_IDX_W-1:0] SLOT_GPIO = 4'd1;   // Full slot
    localparam logic [SLOT_IDX_W-1:0] SLOT_PWM  = 4'd5;   // Byte slot

    // Pin function select: bit 4 picks the byte slots, bits 3:0 the slot
    localparam int FUNC_SEL_W  = 5;
    localparam int AUDIO_SEL_W = 3;   // Top bit enables audio

    // GPIO register map
    localparam logic [FULL_OFS_W-1:0] OFS_GPIO_OUT  = 6'h00;
    localparam logic [FULL_OFS_W-1:0] OFS_GPIO_IN   = 6'h04;
    localparam logic [FULL_OFS_W-1:0] OFS_AUDIO_SEL = 6'h10;
    localparam logic [FULL_OFS_W-1:0] OFS_FUNC_SEL  = 6'h20;   // Plus 4 per pin

    // PWM register map
    localparam logic [BYTE_OFS_W-1:0] OFS_PWM_DUTY = 4'h0;
    localparam logic [BYTE_OFS_W-1:0] OFS_PWM_DIV  = 4'h1;

    // Access size as driven by the core, ACC_NONE when idle
    typedef enum logic [1:0] {
        ACC_BYTE = 2'b00,
        ACC_HALF = 2'b01,
        ACC_WORD = 2'b10,
        ACC_NONE = 2'b11
    } access_t;

    typedef logic [PIN_W-1:0] pin_t;

endpackage

`default_nettype wire

// File: hdl/bus_decode.sv
`timescale 1ns/1ns
`default_nettype none

module bus_decode (
    input  wire [periph_pkg::ADDR_W-1:0]      i_addr,
    input  wire periph_pkg::access_t          i_write_n,
    input  wire periph_pkg::access_t          i_read_n,
    input  wire                               i_hold_ready,
    input  wire [periph_pkg::DATA_W-1:0]      i_gpio_rdata,
    input  wire periph_pkg::pin_t             i_pwm_rdata,
    output logic                              o_gpio_wr,
    output logic                              o_gpio_rd,
    output logic                              o_pwm_wr,
    output logic [periph_pkg::FULL_OFS_W-1:0] o_ofs,
    output logic [periph_pkg::DATA_W-1:0]     o_rdata,
    output logic                              o_rdata_ready
);
    import periph_pkg::*;

    logic                  byte_space;
    logic [SLOT_IDX_W-1:0] full_idx;
    logic [SLOT_IDX_W-1:0] byte_idx;
    logic [NUM_SLOTS-1:0]  full_sel;
    logic [NUM_SLOTS-1:0]  byte_sel;
    logic                  write_req;
    logic                  read_req;

    assign byte_space = i_addr[ADDR_W-1];
    assign full_idx   = i_addr[ADDR_W-2 -: SLOT_IDX_W];   // Bits 9:6
    assign byte_idx   = i_addr[BYTE_OFS_W +: SLOT_IDX_W]; // Bits 7:4
    assign o_ofs      = i_addr[FULL_OFS_W-1:0];

    // One-hot slot select, only one half of the map active at a time
    always_comb begin
        full_sel = '0;
        byte_sel = '0;
        if (byte_space)
            byte_sel[byte_idx] = 1'b1;
        else
            full_sel[full_idx] = 1'b1;
    end

    assign write_req = (i_write_n != ACC_NONE);
    assign read_req  = (i_read_n != ACC_NONE) && !i_hold_ready;  // No re-read while buffered

    assign o_gpio_wr = write_req && full_sel[SLOT_GPIO];
    assign o_gpio_rd = read_req && full_sel[SLOT_GPIO];
    assign o_pwm_wr  = write_req && byte_sel[SLOT_PWM];

    always_comb begin
        o_rdata       = '0;  // Empty slots read zero
        o_rdata_ready = 1'b1; // Kept and empty slots all answer at once
        if (byte_space) begin
            if (byte_sel[SLOT_PWM])
                o_rdata = DATA_W'(i_pwm_rdata);  // Byte data zero-extended
        end else if (full_sel[SLOT_GPIO]) begin
            o_rdata = i_gpio_rdata;
        end
    end

endmodule

`default_nettype wire

// File: hdl/read_capture.sv
`timescale 1ns/1ns
`default_nettype none

module read_capture (
    input  wire                           clk,
    input  wire                           rst_n,
    input  wire                           i_read_req,
    input  wire [periph_pkg::DATA_W-1:0]  i_rdata,
    input  wire                           i_rdata_ready,
    input  wire                           i_write_req,
    input  wire                           i_read_complete,
    output logic [periph_pkg::DATA_W-1:0] o_data,
    output logic                          o_data_ready,
    output logic                          o_hold_ready
);
    import periph_pkg::*;

    logic [DATA_W-1:0] data_r;
    logic              hold_r;
    logic              ready_r;
    logic              capture;

    // First cycle with a served request while nothing is held
    assign capture = !hold_r && i_rdata_ready && i_read_req;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hold_r  <= 1'b0;
            ready_r <= 1'b0;
        end else begin
            if (i_read_complete)
                hold_r <= 1'b0;
            if (capture)
                hold_r <= 1'b1;
            ready_r <= i_read_req && i_rdata_ready;  // Lines up with data_r
        end
    end

    always_ff @(posedge clk) begin
        if (capture)
            data_r <= i_rdata;
    end

    assign o_data       = data_r;
    assign o_data_ready = ready_r || i_write_req;  // Writes complete in the same cycle
    assign o_hold_ready = ready_r;

endmodule

`default_nettype wire

// File: gpio/gpio_regs.sv
`timescale 1ns/1ns
`default_nettype none

module gpio_regs (
    input  wire                               clk,
    input  wire                               rst_n,
    input  wire                               i_wr,
    input  wire                               i_rd,
    input  wire [periph_pkg::FULL_OFS_W-1:0]  i_ofs,
    input  wire [periph_pkg::DATA_W-1:0]      i_wdata,
    input  wire periph_pkg::pin_t             i_ui_in,
    output logic [periph_pkg::DATA_W-1:0]     o_rdata,
    output periph_pkg::pin_t                  o_gpio_out,
    output logic [periph_pkg::FUNC_SEL_W-1:0] o_func_sel [periph_pkg::PIN_W],
    output logic                              o_audio_select
);
    import periph_pkg::*;

    pin_t                      gpio_out_r;
    logic [AUDIO_SEL_W-1:0]    audio_sel_r;
    logic [FUNC_SEL_W-1:0]     func_sel_r [PIN_W];
    logic                      func_hit;
    logic [$clog2(PIN_W)-1:0]  func_idx;

    // Function selects sit at 0x20..0x3c, one word per pin
    assign func_hit = ({i_ofs[FULL_OFS_W-1], i_ofs[1:0]} ==
                       {OFS_FUNC_SEL[FULL_OFS_W-1], OFS_FUNC_SEL[1:0]});
    assign func_idx = i_ofs[2 +: $clog2(PIN_W)];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            gpio_out_r  <= '0;
            audio_sel_r <= '0;
            for (int i = 0; i < PIN_W; i++)
                func_sel_r[i] <= FUNC_SEL_W'(SLOT_GPIO);  // All pins start on GPIO
        end else if (i_wr) begin
            if (i_ofs == OFS_GPIO_OUT)
                gpio_out_r <= i_wdata[PIN_W-1:0];
            if (i_ofs == OFS_AUDIO_SEL)
                audio_sel_r <= i_wdata[AUDIO_SEL_W-1:0];
            if (func_hit)
                func_sel_r[func_idx] <= i_wdata[FUNC_SEL_W-1:0];
        end
    end

    // Readback, input pins are read live
    always_comb begin
        o_rdata = '0;
        if (i_rd) begin
            if (i_ofs == OFS_GPIO_OUT)
                o_rdata = DATA_W'(gpio_out_r);
            else if (i_ofs == OFS_GPIO_IN)
                o_rdata = DATA_W'(i_ui_in);
            else if (i_ofs == OFS_AUDIO_SEL)
                o_rdata = DATA_W'(audio_sel_r);
            else if (func_hit)
                o_rdata = DATA_W'(func_sel_r[func_idx]);
        end
    end

    assign o_gpio_out     = gpio_out_r;
    assign o_func_sel     = func_sel_r;
    assign o_audio_select = audio_sel_r[AUDIO_SEL_W-1];  // Enable bit only

endmodule

`default_nettype wire

// File: gpio/pin_mux.sv
`timescale 1ns/1ns
`default_nettype none

module pin_mux (
    input  wire [periph_pkg::FUNC_SEL_W-1:0] i_func_sel [periph_pkg::PIN_W],
    input  wire periph_pkg::pin_t            i_gpio_out,
    input  wire periph_pkg::pin_t            i_pwm_out,
    output periph_pkg::pin_t                 o_uo_out
);
    import periph_pkg::*;

    // Each pin n takes bit n of whichever slot its select names
    always_comb begin
        for (int n = 0; n < PIN_W; n++) begin
            o_uo_out[n] = 1'b0;  // Empty slots drive low
            if (i_func_sel[n][FUNC_SEL_W-1]) begin
                if (i_func_sel[n][SLOT_IDX_W-1:0] == SLOT_PWM)
                    o_uo_out[n] = i_pwm_out[n];
            end else begin
                if (i_func_sel[n][SLOT_IDX_W-1:0] == SLOT_GPIO)
                    o_uo_out[n] = i_gpio_out[n];
            end
        end
    end

endmodule

`default_nettype wire

// File: pwm/pwm_byte.sv
`timescale 1ns/1ns
`default_nettype none

module pwm_byte (
    input  wire                               clk,
    input  wire                               rst_n,
    input  wire                               i_wr,
    input  wire [periph_pkg::BYTE_OFS_W-1:0]  i_ofs,
    input  wire periph_pkg::pin_t             i_wdata,
    output periph_pkg::pin_t                  o_rdata,
    output periph_pkg::pin_t                  o_pins
);
    import periph_pkg::*;

    pin_t duty_r;
    pin_t div_r;
    pin_t pre_cnt;   // Prescale count
    pin_t pwm_cnt;   // Main PWM counter

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            duty_r <= '0;
            div_r  <= '0;
        end else if (i_wr) begin
            case (i_ofs)
                OFS_PWM_DUTY: duty_r <= i_wdata;
                OFS_PWM_DIV:  div_r  <= i_wdata;
                default: ;
            endcase
        end
    end

    // Counter steps once every div_r + 1 cycles
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pre_cnt <= '0;
            pwm_cnt <= '0;
        end else if (pre_cnt >= div_r) begin  // >= so a smaller divider takes hold at once
            pre_cnt <= '0;
            pwm_cnt <= pwm_cnt + 1'b1;
        end else begin
            pre_cnt <= pre_cnt + 1'b1;
        end
    end

    // Duty of zero never matches, so the output stays low
    assign o_pins = (pwm_cnt < duty_r) ? '1 : '0;

    always_comb begin
        case (i_ofs)
            OFS_PWM_DUTY: o_rdata = duty_r;
            OFS_PWM_DIV:  o_rdata = div_r;
            default:      o_rdata = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: hdl/periph_top.sv
`timescale 1ns/1ns
`default_nettype none

module periph_top (
    input  wire                              clk,
    input  wire                              rst_n,
    input  wire periph_pkg::pin_t            i_ui_in,
    input  wire [periph_pkg::ADDR_W-1:0]     i_addr,
    input  wire [periph_pkg::DATA_W-1:0]     i_data,
    input  wire periph_pkg::access_t         i_write_n,
    input  wire periph_pkg::access_t         i_read_n,
    input  wire                              i_read_complete,
    output periph_pkg::pin_t                 o_uo_out,
    output logic                             o_audio,
    output logic                             o_audio_select,
    output logic [periph_pkg::DATA_W-1:0]    o_data,
    output logic                             o_data_ready
);
    import periph_pkg::*;

    logic                  gpio_wr;
    logic                  gpio_rd;
    logic                  pwm_wr;
    logic [FULL_OFS_W-1:0] ofs;
    logic [DATA_W-1:0]     gpio_rdata;
    pin_t                  pwm_rdata;
    logic [DATA_W-1:0]     slot_rdata;
    logic                  slot_ready;
    logic                  hold_ready;
    pin_t                  gpio_out;
    pin_t                  pwm_pins;
    logic [FUNC_SEL_W-1:0] func_sel [PIN_W];
    logic                  read_req;
    logic                  write_req;

    assign read_req  = (i_read_n != ACC_NONE);
    assign write_req = (i_write_n != ACC_NONE);

    bus_decode u_decode (
        .i_addr        (i_addr),
        .i_write_n     (i_write_n),
        .i_read_n      (i_read_n),
        .i_hold_ready  (hold_ready),
        .i_gpio_rdata  (gpio_rdata),
        .i_pwm_rdata   (pwm_rdata),
        .o_gpio_wr     (gpio_wr),
        .o_gpio_rd     (gpio_rd),
        .o_pwm_wr      (pwm_wr),
        .o_ofs         (ofs),
        .o_rdata       (slot_rdata),
        .o_rdata_ready (slot_ready)
    );

    // Read result is registered here and held for the core
    read_capture u_capture (
        .clk             (clk),
        .rst_n           (rst_n),
        .i_read_req      (read_req),
        .i_rdata         (slot_rdata),
        .i_rdata_ready   (slot_ready),
        .i_write_req     (write_req),
        .i_read_complete (i_read_complete),
        .o_data          (o_data),
        .o_data_ready    (o_data_ready),
        .o_hold_ready    (hold_ready)
    );

    gpio_regs u_gpio (
        .clk            (clk),
        .rst_n          (rst_n),
        .i_wr           (gpio_wr),
        .i_rd           (gpio_rd),
        .i_ofs          (ofs),
        .i_wdata        (i_data),
        .i_ui_in        (i_ui_in),
        .o_rdata        (gpio_rdata),
        .o_gpio_out     (gpio_out),
        .o_func_sel     (func_sel),
        .o_audio_select (o_audio_select)
    );

    pwm_byte u_pwm (
        .clk     (clk),
        .rst_n   (rst_n),
        .i_wr    (pwm_wr),
        .i_ofs   (ofs[BYTE_OFS_W-1:0]),
        .i_wdata (i_data[PIN_W-1:0]),
        .o_rdata (pwm_rdata),
        .o_pins  (pwm_pins)
    );

    pin_mux u_pin_mux (
        .i_func_sel (func_sel),
        .i_gpio_out (gpio_out),
        .i_pwm_out  (pwm_pins),
        .o_uo_out   (o_uo_out)
    );

    assign o_audio = pwm_pins[PIN_W-1];   // PWM top bit feeds the audio pin

endmodule

`default_nettype wire

// File: sim/periph_checker.sv
`timescale 1ns/1ns
`default_nettype none

module periph_checker (
    input  wire                           clk,
    input  wire                           i_rd_active,
    input  wire [periph_pkg::DATA_W-1:0]  i_exp_data,
    input  wire                           i_pin_chk,
    input  wire periph_pkg::pin_t         i_exp_uo,
    input  wire                           i_exp_asel,
    input  wire                           i_exp_audio,
    input  wire [periph_pkg::DATA_W-1:0]  i_data,
    input  wire                           i_data_ready,
    input  wire periph_pkg::pin_t         i_uo_out,
    input  wire                           i_audio,
    input  wire                           i_audio_select,
    output int                            o_data_errs,
    output int                            o_port_errs
);

    int data_errs = 0;
    int port_errs = 0;

    // Read data is compared on the edge where the core sees data ready
    always @(posedge clk) begin
        if (i_rd_active && i_data_ready && i_data !== i_exp_data) begin
            $display("Mismatch o_data: got %h, expected %h", i_data, i_exp_data);
            data_errs++;
        end
    end

    // Pin side, one sample per table entry
    always @(posedge clk) begin
        if (i_pin_chk) begin
            if (i_uo_out !== i_exp_uo) begin
                $display("Mismatch o_uo_out: got %h, expected %h", i_uo_out, i_exp_uo);
                port_errs++;
            end
            if (i_audio_select !== i_exp_asel) begin
                $display("Mismatch o_audio_select: got %h, expected %h",
                         i_audio_select, i_exp_asel);
                port_errs++;
            end
            if (i_audio !== i_exp_audio) begin
                $display("Mismatch o_audio: got %h, expected %h", i_audio, i_exp_audio);
                port_errs++;
            end
        end
    end

    assign o_data_errs = data_errs;
    assign o_port_errs = port_errs;

endmodule

`default_nettype wire

// File: sim/tb_periph.sv
`timescale 1ns/1ns
`default_nettype none

module tb_periph;
    import periph_pkg::*;

    localparam int NUM_ROWS    = 17;
    localparam int RESET_CYC   = 8;
    localparam int READY_LIMIT = 8;   // Cycles a request may wait for data ready
    localparam int MAX_CYCLES  = NUM_ROWS * 8 + RESET_CYC + 20;

    // One bus operation and what the ports should show after it
    typedef struct packed {
        logic              is_wr;
        logic              pin_rd;      // Expected data is the driven input pins
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] wdata;
        logic [DATA_W-1:0] exp_data;
        pin_t              exp_uo;
        logic              exp_asel;
        logic              exp_audio;
    } entry_t;

    logic              clk;
    logic              rst_n;
    pin_t              ui_in;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
    access_t           write_n;
    access_t           read_n;
    logic              read_complete;
    pin_t              uo_out;
    logic              audio;
    logic              audio_select;
    logic [DATA_W-1:0] rdata;
    logic              data_ready;

    logic              rd_active;   // Checker compares o_data while a read is in flight
    logic              pin_chk;
    logic [DATA_W-1:0] exp_data;
    pin_t              exp_uo;
    logic              exp_asel;
    logic              exp_audio;

    entry_t table_mem [NUM_ROWS];
    integer seed = 32'h19ae_8d70;
    int     cycles = 0;
    int     hs_errs = 0;
    int     data_errs;
    int     port_errs;

    always #20 clk = ~clk;

    periph_top dut (
        .clk             (clk),
        .rst_n           (rst_n),
        .i_ui_in         (ui_in),
        .i_addr          (addr),
        .i_data          (wdata),
        .i_write_n       (write_n),
        .i_read_n        (read_n),
        .i_read_complete (read_complete),
        .o_uo_out        (uo_out),
        .o_audio         (audio),
        .o_audio_select  (audio_select),
        .o_data          (rdata),
        .o_data_ready    (data_ready)
    );

    periph_checker u_checker (
        .clk            (clk),
        .i_rd_active    (rd_active),
        .i_exp_data     (exp_data),
        .i_pin_chk      (pin_chk),
        .i_exp_uo       (exp_uo),
        .i_exp_asel     (exp_asel),
        .i_exp_audio    (exp_audio),
        .i_data         (rdata),
        .i_data_ready   (data_ready),
        .i_uo_out       (uo_out),
        .i_audio        (audio),
        .i_audio_select (audio_select),
        .o_data_errs    (data_errs),
        .o_port_errs    (port_errs)
    );

    // Column order is write, pin read, address, write data, read data, uo_out,
    // audio select and audio
    task automatic load_table();
        table_mem[0]  = '{1'b0, 1'b0, 11'h060, 32'h00, 32'h01, 8'h00, 1'b0, 1'b0};
        table_mem[1]  = '{1'b0, 1'b0, 11'h050, 32'h00, 32'h00, 8'h00, 1'b0, 1'b0};
        table_mem[2]  = '{1'b1, 1'b0, 11'h040, 32'hA5, 32'h00, 8'hA5, 1'b0, 1'b0};
        table_mem[3]  = '{1'b0, 1'b0, 11'h040, 32'h00, 32'hA5, 8'hA5, 1'b0, 1'b0};
        table_mem[4]  = '{1'b0, 1'b1, 11'h044, 32'h00, 32'h00, 8'hA5, 1'b0, 1'b0};
        table_mem[5]  = '{1'b0, 1'b0, 11'h0C0, 32'h00, 32'h00, 8'hA5, 1'b0, 1'b0};
        table_mem[6]  = '{1'b1, 1'b0, 11'h450, 32'h00, 32'h00, 8'hA5, 1'b0, 1'b0};
        table_mem[7]  = '{1'b0, 1'b0, 11'h450, 32'h00, 32'h00, 8'hA5, 1'b0, 1'b0};
        table_mem[8]  = '{1'b1, 1'b0, 11'h040, 32'hFF, 32'h00, 8'hFF, 1'b0, 1'b0};
        table_mem[9]  = '{1'b1, 1'b0, 11'h06C, 32'h15, 32'h00, 8'hF7, 1'b0, 1'b0};
        table_mem[10] = '{1'b0, 1'b0, 11'h06C, 32'h00, 32'h15, 8'hF7, 1'b0, 1'b0};
        table_mem[11] = '{1'b1, 1'b0, 11'h070, 32'h03, 32'h00, 8'hE7, 1'b0, 1'b0};
        table_mem[12] = '{1'b1, 1'b0, 11'h050, 32'h04, 32'h00, 8'hE7, 1'b1, 1'b0};
        table_mem[13] = '{1'b0, 1'b0, 11'h050, 32'h00, 32'h04, 8'hE7, 1'b1, 1'b0};
        table_mem[14] = '{1'b1, 1'b0, 11'h451, 32'h00, 32'h00, 8'hE7, 1'b1, 1'b0};
        table_mem[15] = '{1'b1, 1'b0, 11'h450, 32'hFF, 32'h00, 8'hEF, 1'b1, 1'b1};
        table_mem[16] = '{1'b0, 1'b0, 11'h450, 32'h00, 32'hFF, 8'hEF, 1'b1, 1'b1};
    endtask

    // Called and returns 1 ns after a rising edge
    task automatic apply_row(input entry_t row);
        int   waited;
        logic seen;
        waited    = 0;
        seen      = 1'b0;
        addr      = row.addr;
        wdata     = row.wdata;
        exp_data  = row.pin_rd ? DATA_W'(ui_in) : row.exp_data;
        if (row.is_wr) begin
            write_n = ACC_WORD;
        end else begin
            read_n    = ACC_WORD;
            rd_active = 1'b1;
        end
        while (!seen && waited < READY_LIMIT) begin
            @(posedge clk);
            seen = data_ready;
            waited++;
        end
        if (!seen) begin
            $display("Request at address %h got no data ready within %0d cycles",
                     row.addr, READY_LIMIT);
            hs_errs++;
        end
        #1;
        write_n       = ACC_NONE;
        read_n        = ACC_NONE;
        rd_active     = 1'b0;
        read_complete = !row.is_wr;   // Release the held read data
        exp_uo        = row.exp_uo;
        exp_asel      = row.exp_asel;
        exp_audio     = row.exp_audio;
        pin_chk       = 1'b1;
        @(posedge clk);
        #1;
        pin_chk       = 1'b0;
        read_complete = 1'b0;
    endtask

    initial begin
        clk           = 1'b0;
        rst_n         = 1'b0;
        ui_in         = 8'($random(seed));
        addr          = '0;
        wdata         = '0;
        write_n       = ACC_NONE;
        read_n        = ACC_NONE;
        read_complete = 1'b0;
        rd_active     = 1'b0;
        pin_chk       = 1'b0;
        exp_data      = '0;
        exp_uo        = '0;
        exp_asel      = 1'b0;
        exp_audio     = 1'b0;
        load_table();
        repeat (RESET_CYC) @(posedge clk);
        #1;
        rst_n = 1'b1;
        for (int k = 0; k < NUM_ROWS; k++)
            apply_row(table_mem[k]);
        repeat (2) @(posedge clk);
        $display("Errors: data %0d, ports %0d, handshake %0d", data_errs, port_errs, hs_errs);
        if (data_errs + port_errs + hs_errs == 0)
            $display("Test completed successfully");
        else
            $display("Test failed");
        $finish;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout after %0d cycles, the stimulus loop did not finish", cycles);
            $display("Test failed");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: sim.f
common/periph_pkg.sv
hdl/bus_decode.sv
hdl/read_capture.sv
gpio/gpio_regs.sv
gpio/pin_mux.sv
pwm/pwm_byte.sv
hdl/periph_top.sv
sim/periph_checker.sv
sim/tb_periph.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing
TOP       ?= tb_periph
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := Test completed successfully

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
